// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100
LOG       ?= sim.log

SRCS    := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== base_reg_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module base_reg_reader import fetch_pkg::*; (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 reg_we,
   input  wire logic [REG_IDX_W-1:0] reg_idx,
   input  wire word_t                reg_wdata,
   input  wire base_req_t            base_req,
   output base_rsp_t                 base_rsp
);

   word_t     regs [NUM_REGS];
   base_req_t pipe_q [BASE_LAT];

   ////////////////////////////////////////
   // register file
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (reg_we) begin
         regs[reg_idx] <= reg_wdata;
      end
   end

   ////////////////////////////////////////
   // request delay line
   ////////////////////////////////////////
   // stands in for the operand wait of the full pipe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < BASE_LAT; i++) begin
            pipe_q[i] <= '0;
         end
      end else begin
         pipe_q[0] <= base_req;
         for (int i = 1; i < BASE_LAT; i++) begin
            pipe_q[i] <= pipe_q[i-1];
         end
      end
   end

   // last stage reads the file
   assign base_rsp.ready = pipe_q[BASE_LAT-1].valid;
   assign base_rsp.value = regs[pipe_q[BASE_LAT-1].idx];

endmodule

`default_nettype wire

// ==== fetch_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_assert import fetch_pkg::*; (
   input wire logic          clk,
   input wire logic          rst_n,
   input wire logic          ext_pc_en,
   input wire logic          wait_q,
   input wire logic          stall,
   input wire base_req_t     base_req,
   input wire fetch_bundle_t out_bundle
);

   int fails = 0;

   // a request parks the counter and nops the next bundle
   stall_nops: assert property (@(posedge clk) disable iff (!rst_n)
      base_req.valid |=> ext_pc_en || (stall && out_bundle == '0))
      else begin
         fails++;
         $error("bundle not nopped while stalled");
      end

   // one request in flight at most
   no_req_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
      wait_q |-> !base_req.valid)
      else begin
         fails++;
         $error("base request issued while waiting");
      end

   // external load drops the wait at the next edge
   ext_cancels_wait: assert property (@(posedge clk) disable iff (!rst_n)
      ext_pc_en |=> !wait_q)
      else begin
         fails++;
         $error("wait still active after external pc load");
      end

endmodule

bind jump_handler fetch_assert u_fetch_assert (
   .clk        (clk),
   .rst_n      (rst_n),
   .ext_pc_en  (ext_pc_en),
   .wait_q     (wait_q),
   .stall      (stall),
   .base_req   (base_req),
   .out_bundle (out_bundle)
);

`default_nettype wire

// ==== fetch_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc import fetch_pkg::*; (
   input  wire logic  clk,
   input  wire logic  rst_n,
   input  wire logic  jump_sel,
   input  wire word_t jump_addr,
   input  wire logic  stall,
   input  wire logic  ext_pc_en,
   input  wire word_t ext_pc,
   output word_t      pc
);

   word_t pc_next;

   // external load beats jumps, jumps beat the stall
   always_comb begin
      if (ext_pc_en) begin
         pc_next = ext_pc;
      end else if (jump_sel) begin
         pc_next = jump_addr;
      end else if (stall) begin
         pc_next = pc;
      end else begin
         pc_next = pc + word_t'(FETCH_WIDTH);
      end
   end

   // full 16-bit counter, the memory takes the low bits
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else begin
         pc <= pc_next;
      end
   end

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

   ////////////////////////////////////////
   // sizes
   ////////////////////////////////////////
   localparam int WORD_W      = 16;
   localparam int FETCH_WIDTH = 4;
   localparam int SLOT_W      = $clog2(FETCH_WIDTH);
   localparam int IMEM_DEPTH  = 256;
   localparam int IMEM_AW     = $clog2(IMEM_DEPTH);
   localparam int NUM_REGS    = 16;
   localparam int REG_IDX_W   = $clog2(NUM_REGS);
   localparam int BASE_LAT    = 2;

   ////////////////////////////////////////
   // jump encoding
   ////////////////////////////////////////
   localparam logic [3:0] JMP_OPCODE = 4'b1111;
   localparam int JMP_OP_LO = 12;
   // bit 0 set selects the base form
   localparam int JMP_KIND_BIT = 0;
   localparam int IMM_HI  = 11;
   localparam int IMM_LO  = 2;
   localparam int IMM_W   = IMM_HI - IMM_LO + 1;
   localparam int BOFF_HI = 7;
   localparam int BOFF_LO = 2;
   localparam int BOFF_W  = BOFF_HI - BOFF_LO + 1;
   localparam int RIDX_HI = 11;
   localparam int RIDX_LO = 8;

   typedef logic [WORD_W-1:0] word_t;

   // slot 0 sits in the top bits
   typedef struct packed {
      word_t [0:FETCH_WIDTH-1] slot;
   } fetch_bundle_t;

   typedef struct packed {
      logic                 valid;
      logic [REG_IDX_W-1:0] idx;
   } base_req_t;

   typedef struct packed {
      logic  ready;
      word_t value;
   } base_rsp_t;

endpackage

`default_nettype wire

// ==== fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

   // load, reset, then the five tests in order
   localparam int TEST_CYCLES = 256 + 5 + 20 + 20 + 6 + 6 + 10 + 3;
   localparam int MAX_CYCLES  = 2 * TEST_CYCLES;
   localparam word_t EXT_TARGET = 16'd232;
   localparam word_t END_PC     = 16'd240;

   logic                 clk;
   logic                 rst_n;
   logic                 mispredict;
   logic                 ext_pc_en;
   word_t                ext_pc;
   logic                 imem_we;
   word_t                imem_addr;
   word_t                imem_wdata;
   logic                 reg_we;
   logic [REG_IDX_W-1:0] reg_idx;
   word_t                reg_wdata;
   word_t                fetch_pc_q;
   fetch_bundle_t        out_bundle;

   integer seed = 72;
   int     errors = 0;
   int     cycles = 0;
   word_t  img [256];
   word_t  rf [16];

   fetch_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("run stopped, no result after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic word_t imm_target(input word_t addr, input word_t w);
      return addr + 16'd1 + {{6{w[11]}}, w[11:2]};
   endfunction

   function automatic word_t base_target(input word_t value, input word_t w);
      return value + {{10{w[7]}}, w[7:2]};
   endfunction

   function automatic fetch_bundle_t bundle_at(input word_t p);
      fetch_bundle_t b;
      for (int i = 0; i < 4; i++) begin
         b.slot[i] = img[p[7:0] + 8'(i)];
      end
      return b;
   endfunction

   // encoders for the test programs
   function automatic word_t imm_word(input word_t addr, input word_t target);
      word_t off;
      off = target - addr - 16'd1;
      return {4'hF, off[9:0], 2'b00};
   endfunction

   function automatic word_t base_word(input int ridx, input int off);
      logic [5:0] o;
      o = 6'(off);
      return {4'hF, 4'(ridx), o, 2'b01};
   endfunction

   task automatic build_image();
      word_t w;
      for (int a = 0; a < 256; a++) begin
         w = word_t'($random(seed));
         // filler must never decode as a jump
         if (w[15:12] == 4'hF) begin
            w[15] = 1'b0;
         end
         img[a] = w;
      end
      for (int r = 0; r < 16; r++) begin
         rf[r] = word_t'($random(seed));
      end
      img[128] = imm_word(16'd128, 16'd208);
      img[137] = imm_word(16'd137, 16'd20);
      img[146] = imm_word(16'd146, 16'd216);
      img[155] = imm_word(16'd155, 16'd36);
      img[161] = imm_word(16'd161, 16'd224);
      img[163] = base_word(1, 2);
      img[170] = base_word(5, 3);
      img[178] = base_word(9, -2);
      img[180] = base_word(12, 5);
      img[185] = base_word(3, 1);
      img[192] = base_word(7, -4);
   endtask

   task automatic load_memory();
      for (int a = 0; a < 256; a++) begin
         imem_we    = 1'b1;
         imem_addr  = word_t'(a);
         imem_wdata = img[a];
         @(negedge clk);
      end
      imem_we = 1'b0;
   endtask

   task automatic check_cycle(input word_t exp_pc, input logic nopped);
      fetch_bundle_t exp_b;
      exp_b = nopped ? '0 : bundle_at(exp_pc);
      assert (fetch_pc_q == exp_pc) else begin
         errors++;
         $display("Fail fetch_pc_q: got %h, expected %h", fetch_pc_q, exp_pc);
      end
      assert (out_bundle == exp_b) else begin
         errors++;
         $display("Fail out_bundle at pc %h: got %h, expected %h", exp_pc, out_bundle, exp_b);
      end
   endtask

   // also flushes any late base response
   task automatic load_pc(input word_t addr);
      ext_pc    = addr;
      ext_pc_en = 1'b1;
      repeat (2) @(negedge clk);
      ext_pc_en = 1'b0;
   endtask

   ////////////////////////////////////////
   // tests
   ////////////////////////////////////////
   task automatic test_sequential();
      word_t p;
      p = '0;
      for (int n = 0; n < 20; n++) begin
         check_cycle(p, 1'b0);
         // register writeback runs alongside
         reg_we    = (n < 16);
         reg_idx   = 4'(n);
         reg_wdata = rf[n % 16];
         @(negedge clk);
         p = p + 16'd4;
      end
      reg_we = 1'b0;
   endtask

   task automatic imm_case(input word_t start, input word_t jaddr);
      load_pc(start);
      check_cycle(start, 1'b0);
      @(negedge clk);
      check_cycle(imm_target(jaddr, img[jaddr[7:0]]), 1'b0);
   endtask

   task automatic base_case(input word_t start, input word_t jaddr);
      word_t w;
      word_t target;
      w      = img[jaddr[7:0]];
      target = base_target(rf[w[11:8]], w);
      load_pc(start);
      check_cycle(start, 1'b0);
      repeat (3) begin
         @(negedge clk);
         check_cycle(jaddr, 1'b1);
      end
      @(negedge clk);
      check_cycle(target, 1'b0);
   endtask

   task automatic cancel_case(input word_t start, input word_t jaddr, input logic use_ext);
      load_pc(start);
      check_cycle(start, 1'b0);
      @(negedge clk);
      check_cycle(jaddr, 1'b1);
      ext_pc     = EXT_TARGET;
      ext_pc_en  = use_ext;
      mispredict = !use_ext;
      @(negedge clk);
      check_cycle(use_ext ? EXT_TARGET : jaddr, 1'b0);
      ext_pc_en  = 1'b0;
      mispredict = 1'b0;
   endtask

   initial begin
      int afails;
      rst_n      = 1'b0;
      mispredict = 1'b0;
      ext_pc_en  = 1'b0;
      ext_pc     = '0;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      reg_we     = 1'b0;
      reg_idx    = '0;
      reg_wdata  = '0;
      build_image();
      @(negedge clk);
      load_memory();
      repeat (5) @(negedge clk);
      rst_n = 1'b1;

      test_sequential();
      imm_case(16'd128, 16'd128);
      imm_case(16'd136, 16'd137);
      imm_case(16'd144, 16'd146);
      imm_case(16'd152, 16'd155);
      // two jumps, slot 1 beats slot 3
      imm_case(16'd160, 16'd161);
      base_case(16'd168, 16'd170);
      // refetched bundle carries a second base jump
      base_case(16'd176, 16'd178);
      cancel_case(16'd184, 16'd185, 1'b1);
      cancel_case(16'd192, 16'd192, 1'b0);
      load_pc(END_PC);
      check_cycle(END_PC, 1'b0);

      afails = DUT.u_jump_handler.u_fetch_assert.fails;
      $display("summary: %0d check errors, %0d assertion errors", errors, afails);
      if (errors + afails == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== fetch_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 mispredict,
   input  wire logic                 ext_pc_en,
   input  wire word_t                ext_pc,
   input  wire logic                 imem_we,
   input  wire word_t                imem_addr,
   input  wire word_t                imem_wdata,
   input  wire logic                 reg_we,
   input  wire logic [REG_IDX_W-1:0] reg_idx,
   input  wire word_t                reg_wdata,
   output word_t                     fetch_pc_q,
   output fetch_bundle_t             out_bundle
);

   word_t         pc;
   fetch_bundle_t bundle;
   logic          jump_sel;
   word_t         jump_addr;
   logic          stall;
   base_req_t     base_req;
   base_rsp_t     base_rsp;

   fetch_pc u_fetch_pc (
      .clk       (clk),
      .rst_n     (rst_n),
      .jump_sel  (jump_sel),
      .jump_addr (jump_addr),
      .stall     (stall),
      .ext_pc_en (ext_pc_en),
      .ext_pc    (ext_pc),
      .pc        (pc)
   );

   inst_mem u_inst_mem (
      .clk    (clk),
      .we     (imem_we),
      .waddr  (imem_addr),
      .wdata  (imem_wdata),
      .pc     (pc),
      .bundle (bundle)
   );

   jump_handler u_jump_handler (
      .clk        (clk),
      .rst_n      (rst_n),
      .mispredict (mispredict),
      .ext_pc_en  (ext_pc_en),
      .pc         (pc),
      .bundle     (bundle),
      .base_rsp   (base_rsp),
      .base_req   (base_req),
      .jump_sel   (jump_sel),
      .jump_addr  (jump_addr),
      .stall      (stall),
      .out_bundle (out_bundle)
   );

   base_reg_reader u_base_reg_reader (
      .clk       (clk),
      .rst_n     (rst_n),
      .reg_we    (reg_we),
      .reg_idx   (reg_idx),
      .reg_wdata (reg_wdata),
      .base_req  (base_req),
      .base_rsp  (base_rsp)
   );

   assign fetch_pc_q = pc;

endmodule

`default_nettype wire

// ==== inst_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_mem import fetch_pkg::*; (
   input  wire logic  clk,
   input  wire logic  we,
   input  wire word_t waddr,
   input  wire word_t wdata,
   input  wire word_t pc,
   output fetch_bundle_t bundle
);

   word_t mem [IMEM_DEPTH];
   logic [IMEM_AW-1:0] rd_base;

   // program load port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr[IMEM_AW-1:0]] <= wdata;
      end
   end

   assign rd_base = pc[IMEM_AW-1:0];

   // four words from pc, index wraps at the top of the array
   always_comb begin
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         bundle.slot[i] = mem[rd_base + IMEM_AW'(i)];
      end
   end

endmodule

`default_nettype wire

// ==== jump_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module jump_handler import fetch_pkg::*; (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire logic          mispredict,
   input  wire logic          ext_pc_en,
   input  wire word_t         pc,
   input  wire fetch_bundle_t bundle,
   input  wire base_rsp_t     base_rsp,
   output base_req_t          base_req,
   output logic               jump_sel,
   output word_t              jump_addr,
   output logic               stall,
   output fetch_bundle_t      out_bundle
);

   logic              hit;
   logic              hit_base;
   logic [SLOT_W-1:0] hit_slot;
   word_t             hit_word;
   word_t             slot_addr;
   word_t             imm_off;
   word_t             base_off;
   logic              imm_det;
   logic              base_det;
   logic              cancel;
   logic              sel;
   logic              wait_q;
   logic              dis_q;
   logic              rdy_q;
   word_t             base_q;
   word_t             off_q;

   ////////////////////////////////////////
   // slot scan
   ////////////////////////////////////////
   // first jump in the bundle wins, whatever its kind
   always_comb begin
      hit      = 1'b0;
      hit_base = 1'b0;
      hit_slot = '0;
      hit_word = '0;
      for (int i = 0; i < FETCH_WIDTH; i++) begin
         if (!hit && bundle.slot[i][WORD_W-1:JMP_OP_LO] == JMP_OPCODE) begin
            hit      = 1'b1;
            hit_base = bundle.slot[i][JMP_KIND_BIT];
            hit_slot = SLOT_W'(i);
            hit_word = bundle.slot[i];
         end
      end
   end

   assign slot_addr = pc + word_t'(hit_slot);
   assign imm_off   = {{(WORD_W-IMM_W){hit_word[IMM_HI]}}, hit_word[IMM_HI:IMM_LO]};
   assign base_off  = {{(WORD_W-BOFF_W){hit_word[BOFF_HI]}}, hit_word[BOFF_HI:BOFF_LO]};

   assign cancel   = mispredict | ext_pc_en;
   assign imm_det  = hit & ~hit_base;
   // no new base request until the previous one has been used
   assign base_det = hit & hit_base & ~dis_q & ~cancel;

   assign base_req.valid = base_det;
   assign base_req.idx   = hit_word[RIDX_HI:RIDX_LO];

   ////////////////////////////////////////
   // wait state
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wait_q <= 1'b0;
         dis_q  <= 1'b0;
         rdy_q  <= 1'b0;
      end else begin
         // a late ready still lands once, even after a cancel
         rdy_q <= base_rsp.ready;
         if (cancel) begin
            wait_q <= 1'b0;
            dis_q  <= 1'b0;
         end else begin
            if (base_det) begin
               wait_q <= 1'b1;
            end else if (base_rsp.ready) begin
               wait_q <= 1'b0;
            end
            // stays set through the buffered ready cycle
            if (base_rsp.ready) begin
               dis_q <= 1'b1;
            end else begin
               dis_q <= wait_q | base_det;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      base_q <= base_rsp.value;
      if (base_det) begin
         off_q <= base_off;
      end
   end

   ////////////////////////////////////////
   // redirect and stall
   ////////////////////////////////////////
   always_comb begin
      if (rdy_q) begin
         sel       = 1'b1;
         jump_addr = base_q + off_q;
      end else if (wait_q) begin
         sel       = 1'b0;
         jump_addr = '0;
      end else if (base_det) begin
         // park on the jump itself until the base arrives
         sel       = 1'b1;
         jump_addr = slot_addr;
      end else if (imm_det) begin
         sel       = 1'b1;
         jump_addr = slot_addr + word_t'(1) + imm_off;
      end else begin
         sel       = 1'b0;
         jump_addr = '0;
      end
   end

   assign jump_sel = sel & ~ext_pc_en;
   assign stall    = wait_q & ~ext_pc_en;

   // nops while parked and in the landing cycle
   assign out_bundle = ((wait_q | rdy_q) && !ext_pc_en) ? '0 : bundle;

endmodule

`default_nettype wire

// ==== sources.f ====
fetch_pkg.sv
fetch_pc.sv
inst_mem.sv
jump_handler.sv
base_reg_reader.sv
fetch_top.sv
fetch_assert.sv
fetch_tb.sv
